// ==== lsu_pkg.sv ====
package lsu_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] xlen_t;
	typedef logic [63:0] bus_data_t;
	typedef logic [7:0]  strb_t;
	typedef logic [2:0]  axsize_t;
	typedef logic [1:0]  resp_t;
	typedef logic [4:0]  reg_idx_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

	// funct3 encodings of the RV32 load and store instructions
	typedef enum logic [2:0] {
		LS_B  = 3'd0,
		LS_H  = 3'd1,
		LS_W  = 3'd2,
		LS_BU = 3'd4,
		LS_HU = 3'd5
	} ls_width_e;

	typedef enum logic [2:0] {
		LSU_IDLE,
		LSU_AR,   // read address offered
		LSU_R,    // waiting for read data
		LSU_AW_W, // write address and data offered together
		LSU_B     // waiting for write response
	} lsu_state_e;

endpackage

// ==== lsu_core.sv ====
`timescale 1ns/10ps

module lsu_core import lsu_pkg::*; #(
	parameter addr_t MEM_BASE  = 32'h8000_0000,
	parameter int    MEM_BEATS = 512
) (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      ren,
	input  logic      wen,
	input  ls_width_e funct3,
	input  xlen_t     src1,
	input  xlen_t     src2,
	input  xlen_t     imm,
	input  reg_idx_t  rd,

	output addr_t     araddr,
	output axsize_t   arsize,
	output logic      arvalid,
	input  logic      arready,
	input  bus_data_t rdata,
	input  resp_t     rresp,
	input  logic      rvalid,
	output logic      rready,

	output addr_t     awaddr,
	output axsize_t   awsize,
	output logic      awvalid,
	input  logic      awready,
	output bus_data_t wdata,
	output strb_t     wstrb,
	output logic      wvalid,
	input  logic      wready,
	input  resp_t     bresp,
	input  logic      bvalid,
	output logic      bready,

	output logic      ld_done,
	output logic      st_done,
	output logic      busy,
	output logic      err,
	output reg_idx_t  ld_rd,
	output xlen_t     ld_val
);

	lsu_state_e state;
	addr_t      req_addr;
	addr_t      addr_q;
	logic       accept;
	strb_t      byte_mask;
	xlen_t      rd_word;
	xlen_t      rd_shift;
	xlen_t      rd_ext;

	assign req_addr = src1 + imm;
	assign accept   = (state == LSU_IDLE) && (ren || wen);

	assign araddr  = addr_q;
	assign awaddr  = addr_q;
	assign arsize  = {1'b0, funct3[1:0]}; // 1, 2 or 4 bytes
	assign awsize  = {1'b0, funct3[1:0]};
	assign arvalid = (state == LSU_AR);
	assign awvalid = (state == LSU_AW_W);
	assign wvalid  = (state == LSU_AW_W);
	assign rready  = 1'b1;
	assign bready  = 1'b1;

	// the done cycle still counts as busy
	assign busy = (state != LSU_IDLE) || ld_done || st_done;

	always_comb begin
		case (funct3)
			LS_B, LS_BU: byte_mask = 8'h01;
			LS_H, LS_HU: byte_mask = 8'h03;
			default:     byte_mask = 8'h0f;
		endcase
	end

	assign wstrb = byte_mask << addr_q[2:0];
	assign wdata = {32'b0, src2} << {addr_q[2:0], 3'b000}; // move store data into its lane

	always_comb begin
		rd_word  = addr_q[2] ? rdata[63:32] : rdata[31:0];
		rd_shift = rd_word >> {addr_q[1:0], 3'b000};
		case (funct3)
			LS_B:    rd_ext = {{24{rd_shift[7]}}, rd_shift[7:0]};
			LS_H:    rd_ext = {{16{rd_shift[15]}}, rd_shift[15:0]};
			LS_BU:   rd_ext = {24'b0, rd_shift[7:0]};
			LS_HU:   rd_ext = {16'b0, rd_shift[15:0]};
			default: rd_ext = rd_shift;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state   <= LSU_IDLE;
			ld_done <= 1'b0;
			st_done <= 1'b0;
			err     <= 1'b0;
		end else begin
			ld_done <= 1'b0;
			st_done <= 1'b0;
			case (state)
				LSU_IDLE: begin
					if (ren) begin
						state <= LSU_AR;
						err   <= 1'b0;
					end else if (wen) begin
						state <= LSU_AW_W;
						err   <= 1'b0;
					end
				end
				LSU_AR: begin
					if (arready)
						state <= LSU_R;
				end
				LSU_R: begin
					if (rvalid) begin
						state   <= LSU_IDLE;
						ld_done <= 1'b1;
						err     <= (rresp == RESP_SLVERR);
					end
				end
				LSU_AW_W: begin
					if (awready && wready)
						state <= LSU_B;
				end
				LSU_B: begin
					if (bvalid) begin
						state   <= LSU_IDLE;
						st_done <= 1'b1;
						err     <= (bresp == RESP_SLVERR);
					end
				end
				default: state <= LSU_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			addr_q <= req_addr;
			ld_rd  <= rd;
		end
		if (state == LSU_R && rvalid)
			ld_val <= rd_ext;
	end

	a_no_strobe_busy: assert property (@(posedge clock) disable iff (!rst_n)
		busy |-> !(ren || wen));

	a_ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize));

	a_aw_w_hold: assert property (@(posedge clock) disable iff (!rst_n)
		awvalid && !(awready && wready) |=> awvalid && wvalid && $stable(awaddr)
			&& $stable(wdata) && $stable(wstrb));

	// halfwords on even bytes, words on multiples of four
	a_aligned: assert property (@(posedge clock) disable iff (!rst_n)
		accept |-> !(funct3[0] && req_addr[0]) && !(funct3[1] && (req_addr[1:0] != 2'b00)));

	// the slave must flag exactly the accesses that miss the memory window
	a_err_window: assert property (@(posedge clock) disable iff (!rst_n)
		(ld_done || st_done) |-> err == ((addr_q < MEM_BASE)
			|| ((addr_q - MEM_BASE) >= (addr_t'(MEM_BEATS) << 3))));

endmodule

// ==== data_sram.sv ====
`timescale 1ns/10ps

module data_sram import lsu_pkg::*; #(
	parameter addr_t MEM_BASE  = 32'h8000_0000,
	parameter int    MEM_BEATS = 512
) (
	input  logic      clock,
	input  logic      rst_n,

	input  addr_t     araddr,
	input  axsize_t   arsize,
	input  logic      arvalid,
	output logic      arready,
	output bus_data_t rdata,
	output resp_t     rresp,
	output logic      rvalid,
	input  logic      rready,

	input  addr_t     awaddr,
	input  axsize_t   awsize,
	input  logic      awvalid,
	output logic      awready,
	input  bus_data_t wdata,
	input  strb_t     wstrb,
	input  logic      wvalid,
	output logic      wready,
	output resp_t     bresp,
	output logic      bvalid,
	input  logic      bready
);

	localparam int    IDX_W     = $clog2(MEM_BEATS);
	localparam addr_t MEM_BYTES = addr_t'(MEM_BEATS) << 3;

	bus_data_t mem [MEM_BEATS];

	logic pending;
	logic ar_hs;
	logic aw_hs;
	logic rd_ok;
	logic wr_ok;

	// inside the window and no wider than one beat
	function automatic logic access_ok(addr_t addr, axsize_t size);
		addr_t offset;
		offset = addr - MEM_BASE;
		return (addr >= MEM_BASE) && (offset < MEM_BYTES) && (size <= 3'd3);
	endfunction

	function automatic logic [IDX_W-1:0] beat_idx(addr_t addr);
		addr_t offset;
		offset = addr - MEM_BASE;
		return offset[3 +: IDX_W];
	endfunction

	assign pending = rvalid || bvalid;

	// single port so a waiting read wins over a write
	assign arready = !pending;
	assign awready = awvalid && wvalid && !pending && !arvalid;
	assign wready  = awready;

	assign ar_hs = arvalid && arready;
	assign aw_hs = awvalid && awready;
	assign rd_ok = access_ok(araddr, arsize);
	assign wr_ok = access_ok(awaddr, awsize);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			if (ar_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (aw_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_hs) begin
			rdata <= rd_ok ? mem[beat_idx(araddr)] : '0;
			rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
		if (aw_hs) begin
			bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			if (wr_ok) begin
				for (int i = 0; i < 8; i++) begin
					if (wstrb[i])
						mem[beat_idx(awaddr)][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// one access at a time, so no new request shows up before its response is taken
	a_no_overtake: assert property (@(posedge clock) disable iff (!rst_n)
		pending |-> !arvalid && !awvalid && !wvalid);

endmodule

// ==== wb_regfile.sv ====
`timescale 1ns/10ps

module wb_regfile import lsu_pkg::*; (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     ld_done,
	input  reg_idx_t ld_rd,
	input  xlen_t    ld_val,
	input  reg_idx_t dbg_raddr,
	output xlen_t    dbg_rdata
);

	xlen_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (ld_done && (ld_rd != '0)) begin
			regs[ld_rd] <= ld_val;
		end
	end

	assign dbg_rdata = (dbg_raddr == '0) ? '0 : regs[dbg_raddr];

endmodule

// ==== lsu_subsys.sv ====
`timescale 1ns/10ps

module lsu_subsys import lsu_pkg::*; #(
	parameter addr_t MEM_BASE  = 32'h8000_0000,
	parameter int    MEM_BEATS = 512
) (
	input  logic      clock,
	input  logic      rst_n,
	input  logic      ren,
	input  logic      wen,
	input  ls_width_e funct3,
	input  xlen_t     src1,
	input  xlen_t     src2,
	input  xlen_t     imm,
	input  reg_idx_t  rd,
	input  reg_idx_t  dbg_raddr,
	output logic      busy,
	output logic      ld_done,
	output logic      st_done,
	output logic      err,
	output xlen_t     dbg_rdata
);

	addr_t     araddr;
	axsize_t   arsize;
	logic      arvalid;
	logic      arready;
	bus_data_t rdata;
	resp_t     rresp;
	logic      rvalid;
	logic      rready;

	addr_t     awaddr;
	axsize_t   awsize;
	logic      awvalid;
	logic      awready;
	bus_data_t wdata;
	strb_t     wstrb;
	logic      wvalid;
	logic      wready;
	resp_t     bresp;
	logic      bvalid;
	logic      bready;

	reg_idx_t  ld_rd;
	xlen_t     ld_val;

	lsu_core #(
		.MEM_BASE  (MEM_BASE),
		.MEM_BEATS (MEM_BEATS)
	) lsu0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.ren     (ren),
		.wen     (wen),
		.funct3  (funct3),
		.src1    (src1),
		.src2    (src2),
		.imm     (imm),
		.rd      (rd),
		.araddr  (araddr),
		.arsize  (arsize),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.awaddr  (awaddr),
		.awsize  (awsize),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.ld_done (ld_done),
		.st_done (st_done),
		.busy    (busy),
		.err     (err),
		.ld_rd   (ld_rd),
		.ld_val  (ld_val)
	);

	data_sram #(
		.MEM_BASE  (MEM_BASE),
		.MEM_BEATS (MEM_BEATS)
	) mem0 (
		.clock   (clock),
		.rst_n   (rst_n),
		.araddr  (araddr),
		.arsize  (arsize),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.awaddr  (awaddr),
		.awsize  (awsize),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready)
	);

	wb_regfile rf0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.ld_done   (ld_done),
		.ld_rd     (ld_rd),
		.ld_val    (ld_val),
		.dbg_raddr (dbg_raddr),
		.dbg_rdata (dbg_rdata)
	);

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clock
);

	localparam real HALF_PERIOD = 2.0; // 4 ns period

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

endmodule

// ==== tb_lsu_subsys.sv ====
`timescale 1ns/10ps

module tb_lsu_subsys import lsu_pkg::*; ();

	localparam addr_t MEM_BASE  = 32'h8000_0000;
	localparam int    MEM_BEATS = 512;
	localparam int    MEM_BYTES = MEM_BEATS * 8;

	typedef struct packed {
		logic      store;
		ls_width_e width;
		xlen_t     src1;
		xlen_t     imm;
		xlen_t     src2;
		reg_idx_t  rd;
		xlen_t     exp_val;
		logic      exp_err;
	} row_t;

	logic      clock;
	logic      rst_n;
	logic      ren;
	logic      wen;
	ls_width_e funct3;
	xlen_t     src1;
	xlen_t     src2;
	xlen_t     imm;
	reg_idx_t  rd;
	reg_idx_t  dbg_raddr;
	logic      busy;
	logic      ld_done;
	logic      st_done;
	logic      err;
	xlen_t     dbg_rdata;

	row_t       rows[$];
	logic [7:0] shadow [MEM_BYTES]; // byte image of the memory window
	xlen_t      shadow_regs [32];
	int         cycle_count = 0;
	int         cycle_limit = 0;

	tb_clock_gen clk0 (.clock(clock));

	lsu_subsys #(
		.MEM_BASE  (MEM_BASE),
		.MEM_BEATS (MEM_BEATS)
	) dut0 (
		.clock     (clock),
		.rst_n     (rst_n),
		.ren       (ren),
		.wen       (wen),
		.funct3    (funct3),
		.src1      (src1),
		.src2      (src2),
		.imm       (imm),
		.rd        (rd),
		.dbg_raddr (dbg_raddr),
		.busy      (busy),
		.ld_done   (ld_done),
		.st_done   (st_done),
		.err       (err),
		.dbg_rdata (dbg_rdata)
	);

	task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// runs the access through the shadow model and appends it with its expected result
	task automatic add_row(input logic store, input ls_width_e width, input xlen_t base,
			input xlen_t imm_val, input xlen_t data, input reg_idx_t dest);
		row_t  r;
		addr_t addr;
		logic  in_win;
		int    nbytes;
		xlen_t raw;
		addr = base + imm_val;
		in_win = (addr >= MEM_BASE) && ((addr - MEM_BASE) < MEM_BYTES);
		nbytes = (width == LS_W) ? 4 : (width == LS_H || width == LS_HU) ? 2 : 1;
		raw = '0;
		for (int i = 0; i < nbytes; i++) begin
			if (store && in_win)
				shadow[addr - MEM_BASE + i] = data[8*i +: 8];
			else if (!store && in_win)
				raw[8*i +: 8] = shadow[addr - MEM_BASE + i];
		end
		if (width == LS_B && raw[7])
			raw[31:8] = '1;
		if (width == LS_H && raw[15])
			raw[31:16] = '1;
		if (!store && dest != 0)
			shadow_regs[dest] = raw; // a missed load still writes zero
		r.store = store;
		r.width = width;
		r.src1 = base;
		r.imm = imm_val;
		r.src2 = data;
		r.rd = dest;
		r.exp_val = shadow_regs[dest];
		r.exp_err = !in_win;
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic      store;
		ls_width_e width;
		int        nb;
		addr_t     off;
		xlen_t     imm_val;
		add_row(1'b1, LS_W, MEM_BASE, 32'h0, 32'h0bad_f00d, 5'd0);
		add_row(1'b1, LS_W, MEM_BASE, 32'h100, 32'h1122_8384, 5'd0);
		add_row(1'b1, LS_W, MEM_BASE + 32'h200, 32'hffff_ff04, 32'hf5e6_7788, 5'd0);
		add_row(1'b0, LS_W, MEM_BASE, 32'h100, 32'h0, 5'd5);
		add_row(1'b0, LS_W, MEM_BASE + 32'h200, 32'hffff_ff04, 32'h0, 5'd6);
		for (int i = 0; i < 8; i++)
			add_row(1'b1, LS_B, MEM_BASE + 32'h108, i, 32'h7f + 32'h23 * i, 5'd0);
		for (int i = 0; i < 8; i++) begin
			add_row(1'b0, LS_B, MEM_BASE + 32'h108, i, 32'h0, 7 + i);
			add_row(1'b0, LS_BU, MEM_BASE + 32'h108, i, 32'h0, 15 + i);
		end
		for (int i = 0; i < 4; i++) begin
			add_row(1'b1, LS_H, MEM_BASE + 32'h110, 2 * i, 32'h6a5c + 32'h3e71 * i, 5'd0);
			add_row(1'b0, LS_H, MEM_BASE + 32'h110, 2 * i, 32'h0, 23 + i);
			add_row(1'b0, LS_HU, MEM_BASE + 32'h110, 2 * i, 32'h0, 27 + i);
		end
		add_row(1'b0, LS_W, MEM_BASE, 32'h100, 32'h0, 5'd0);
		add_row(1'b0, LS_W, 32'h7fff_fff0, 32'h0, 32'h0, 5'd6);
		add_row(1'b1, LS_W, MEM_BASE + MEM_BYTES, 32'h0, 32'hdead_beef, 5'd0); // lands on beat 0 if decoded wrong
		add_row(1'b1, LS_B, 32'h0000_0013, 32'h0, 32'h55, 5'd0);
		add_row(1'b0, LS_W, MEM_BASE, 32'h0, 32'h0, 5'd8);
		for (int i = 0; i < 16; i++)
			add_row(1'b1, LS_W, MEM_BASE + 32'h400, 4 * i, $urandom, 5'd0);
		for (int i = 0; i < 200; i++) begin
			store = $urandom_range(1, 0);
			case ($urandom_range(store ? 2 : 4, 0))
				0: width = LS_B;
				1: width = LS_H;
				2: width = LS_W;
				3: width = LS_BU;
				default: width = LS_HU;
			endcase
			nb = (width == LS_W) ? 4 : (width == LS_H || width == LS_HU) ? 2 : 1;
			off = 32'h400 + ($urandom_range(63, 0) & ~(nb - 1));
			imm_val = $urandom_range(127, 0) - 64;
			add_row(store, width, MEM_BASE + off - imm_val, imm_val, $urandom,
				$urandom_range(31, 0));
		end
	endtask

	task automatic apply_row(input row_t r, input int idx);
		int waited;
		funct3 = r.width;
		src1 = r.src1;
		imm = r.imm;
		src2 = r.src2;
		rd = r.rd;
		ren = !r.store;
		wen = r.store;
		@(negedge clock);
		ren = 1'b0;
		wen = 1'b0;
		waited = 1;
		while (!(ld_done || st_done)) begin
			check_equal($sformatf("row %0d busy while waiting", idx), busy, 1'b1);
			@(negedge clock);
			waited++;
		end
		check_equal($sformatf("row %0d done latency", idx), waited, 3);
		check_equal($sformatf("row %0d st_done", idx), st_done, r.store);
		check_equal($sformatf("row %0d ld_done", idx), ld_done, !r.store);
		check_equal($sformatf("row %0d busy", idx), busy, 1'b1);
		check_equal($sformatf("row %0d err", idx), err, r.exp_err);
		dbg_raddr = r.rd;
		@(negedge clock); // register is written at the end of the done cycle
		check_equal($sformatf("row %0d x%0d", idx, r.rd), dbg_rdata, r.exp_val);
		check_equal($sformatf("row %0d busy after done", idx), busy, 1'b0);
	endtask

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the run took more than %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	initial begin
		void'($urandom(32'h5ae6_924a));
		rst_n = 1'b0;
		ren = 1'b0;
		wen = 1'b0;
		funct3 = LS_W;
		src1 = '0;
		src2 = '0;
		imm = '0;
		rd = '0;
		dbg_raddr = '0;
		for (int i = 0; i < 32; i++)
			shadow_regs[i] = '0;
		build_table();
		cycle_limit = rows.size() * 8 + 100;
		repeat (10) @(negedge clock);
		rst_n = 1'b1;
		check_equal("busy after reset", busy, 1'b0);
		check_equal("ld_done after reset", ld_done, 1'b0);
		check_equal("st_done after reset", st_done, 1'b0);
		check_equal("err after reset", err, 1'b0);
		for (int i = 0; i < 32; i++) begin
			dbg_raddr = i;
			@(negedge clock);
			check_equal($sformatf("x%0d after reset", i), dbg_rdata, 32'h0);
		end
		for (int i = 0; i < rows.size(); i++)
			apply_row(rows[i], i);
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== project.f ====
lsu_pkg.sv
lsu_core.sv
data_sram.sv
wb_regfile.sv
lsu_subsys.sv
tb_clock_gen.sv
tb_lsu_subsys.sv
